// ==== logic/arm_macros.svh ====
`ifndef ARM_MACROS_SVH
`define ARM_MACROS_SVH

// fixed point format, signed q16.16
`define FIX_W 32
`define FRAC_W 16

// arm geometry and state vector
`define NUM_STATE 5 // base x, base y, three joint angles
`define NUM_LINKS 3

// host command
`define NUM_ARGS 4 // count bytes after the command byte
`define CMD_BYTE 8'h68 // ascii h

`define STEP_SHIFT 7 // gradient step, divide by 128

// cordic
`define CORDIC_ITERS 16
`define CORDIC_GAIN_INV 39797 // 0.607253 in q16.16
`define PI_FIX 205887
`define HALF_PI_FIX 102944

`define OUT_BYTES 8 // tip x then tip y, msb first

`endif

// ==== logic/arm_pkg.sv ====
`include "arm_macros.svh"

package arm_pkg;

  // one q16.16 word
  typedef logic signed [`FIX_W-1:0] fix_t;

  // base x, base y, joint 0..2
  typedef fix_t state_vec_t [`NUM_STATE];

  // x sits in the upper half when packed
  typedef struct packed {
    fix_t x;
    fix_t y;
  } point_t;

  // smoothness bias per state word
  localparam state_vec_t bias_vec = '{
    -(fix_t'(7) <<< (`FRAC_W - 1)), // -3.5
    -(fix_t'(7) <<< (`FRAC_W - 1)), // -3.5
    fix_t'(51472), // +pi/4
    fix_t'(51472),
    fix_t'(-51472) // -pi/4
  };

  // round(65536 * atan(2^-i))
  localparam fix_t atan_table [`CORDIC_ITERS] = '{
    fix_t'(51472), fix_t'(30386), fix_t'(16055), fix_t'(8150),
    fix_t'(4091), fix_t'(2047), fix_t'(1024), fix_t'(512),
    fix_t'(256), fix_t'(128), fix_t'(64), fix_t'(32),
    fix_t'(16), fix_t'(8), fix_t'(4), fix_t'(2)
  };

endpackage

// ==== logic/trig_if.sv ====
`timescale 1ns/1ps

// sine/cosine request path, four-phase req/ack
interface trig_if import arm_pkg::*; ();

  fix_t angle;   // absolute link angle, within +-pi
  fix_t cos_out;
  fix_t sin_out;
  logic req;     // held until ack seen
  logic ack;     // held until req drops

  modport client (output angle, output req, input cos_out, input sin_out, input ack);

  modport server (input angle, input req, output cos_out, output sin_out, output ack);

endinterface

// ==== logic/cmd_receiver.sv ====
`timescale 1ns/1ps
`include "arm_macros.svh"

module cmd_receiver (
  input  logic        clk,
  input  logic        rst,
  input  logic [7:0]  rx_data,
  input  logic        new_rx_data,
  input  logic        busy,
  output logic        start,
  output logic [31:0] iter_count
);

  localparam int CNT_W = $clog2(`NUM_ARGS);

  typedef enum logic [1:0] {
    IDLE,    // looking for the command byte
    COLLECT, // shifting in count bytes
    RUN,     // solver busy, result not yet in the sender
    DRAIN    // sender still pushing bytes out
  } rx_state_t;

  rx_state_t fsm;
  logic [CNT_W-1:0] arg_cnt;
  logic byte_ok;

  assign byte_ok = new_rx_data && !busy; // nothing taken while sending

  always_ff @(posedge clk) begin
    if (rst) begin
      fsm <= IDLE;
      arg_cnt <= '0;
      start <= 1'b0;
    end else begin
      start <= 1'b0; // one cycle pulse
      case (fsm)
        IDLE: begin
          if (byte_ok && rx_data == `CMD_BYTE) begin
            arg_cnt <= '0;
            fsm <= COLLECT;
          end
          // anything else is dropped
        end
        COLLECT: begin
          if (byte_ok) begin
            arg_cnt <= arg_cnt + 1'b1;
            if (arg_cnt == CNT_W'(`NUM_ARGS - 1)) begin
              start <= 1'b1; // count complete in iter_count
              fsm <= RUN;
            end
          end
        end
        RUN: if (busy) fsm <= DRAIN;  // result reached the sender
        DRAIN: if (!busy) fsm <= IDLE; // last byte gone
        default: fsm <= IDLE;
      endcase
    end
  end

  // count bytes, first one ends up most significant
  always_ff @(posedge clk) begin
    if (fsm == COLLECT && byte_ok)
      iter_count <= {iter_count[23:0], rx_data};
  end

endmodule

// ==== logic/grad_stepper.sv ====
`timescale 1ns/1ps
`include "arm_macros.svh"

module grad_stepper import arm_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        start,
  input  logic [31:0] iter_count,
  output state_vec_t  state,
  output logic        steps_done
);

  logic [31:0] remaining; // steps still to run
  logic running;
  state_vec_t next_state;

  // smoothness gradient is bias + state, step is gradient / 128
  always_comb begin
    for (int i = 0; i < `NUM_STATE; i++) begin
      next_state[i] = state[i] - ((bias_vec[i] + state[i]) >>> `STEP_SHIFT);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= '{default: '0}; // zero pose
      remaining <= '0;
      running <= 1'b0;
      steps_done <= 1'b0;
    end else begin
      steps_done <= 1'b0;
      if (start && !running) begin
        if (iter_count == '0) begin
          steps_done <= 1'b1; // nothing to do, report next cycle
        end else begin
          remaining <= iter_count;
          running <= 1'b1;
        end
      end else if (running) begin
        state <= next_state; // one step per clock
        remaining <= remaining - 1'b1;
        if (remaining == 32'd1) begin
          // done flag lines up with the last update
          running <= 1'b0;
          steps_done <= 1'b1;
        end
      end
    end
  end

  // state is not touched between commands, next count continues from here

endmodule

// ==== logic/cordic_rotator.sv ====
`timescale 1ns/1ps
`include "arm_macros.svh"

module cordic_rotator import arm_pkg::*; (
  input logic clk,
  input logic rst,
  trig_if.server trig
);

  localparam int ITER_W = $clog2(`CORDIC_ITERS);
  localparam fix_t K = `CORDIC_GAIN_INV; // prescaled start length
  localparam fix_t HALF_PI = `HALF_PI_FIX;

  typedef enum logic [1:0] {
    IDLE,   // wait for req
    ROTATE, // micro-rotations
    FINISH, // publish result
    HOLD    // ack high until req drops
  } cordic_state_t;

  cordic_state_t fsm;
  logic [ITER_W-1:0] iter;
  fix_t x;
  fix_t y;
  fix_t z; // residual angle
  fix_t x_sh;
  fix_t y_sh;

  assign x_sh = x >>> iter;
  assign y_sh = y >>> iter;

  always_ff @(posedge clk) begin
    if (rst) begin
      fsm <= IDLE;
      iter <= '0;
      trig.ack <= 1'b0;
    end else begin
      case (fsm)
        IDLE: begin
          if (trig.req) begin
            iter <= '0;
            fsm <= ROTATE;
          end
        end
        ROTATE: begin
          iter <= iter + 1'b1;
          if (iter == ITER_W'(`CORDIC_ITERS - 1))
            fsm <= FINISH;
        end
        FINISH: begin
          trig.ack <= 1'b1; // cos/sin valid from here
          fsm <= HOLD;
        end
        HOLD: begin
          if (!trig.req) begin
            trig.ack <= 1'b0;
            fsm <= IDLE;
          end
        end
        default: fsm <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (fsm)
      IDLE: begin
        if (trig.req) begin
          // fold into +-pi/2 by a quarter turn of the start vector
          if (trig.angle > HALF_PI) begin
            x <= '0;
            y <= K;
            z <= trig.angle - HALF_PI;
          end else if (trig.angle < -HALF_PI) begin
            x <= '0;
            y <= -K;
            z <= trig.angle + HALF_PI;
          end else begin
            x <= K;
            y <= '0;
            z <= trig.angle;
          end
        end
      end
      ROTATE: begin
        if (!z[`FIX_W-1]) begin // residual positive, rotate ccw
          x <= x - y_sh;
          y <= y + x_sh;
          z <= z - atan_table[iter];
        end else begin
          x <= x + y_sh;
          y <= y - x_sh;
          z <= z + atan_table[iter];
        end
      end
      FINISH: begin
        trig.cos_out <= x;
        trig.sin_out <= y;
      end
      default: ;
    endcase
  end

endmodule

// ==== logic/link_chain.sv ====
`timescale 1ns/1ps
`include "arm_macros.svh"

module link_chain import arm_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       steps_done,
  input  state_vec_t state,
  trig_if.client     trig,
  output logic       tip_valid,
  output point_t     tip
);

  localparam int LINK_W = $clog2(`NUM_LINKS);
  localparam fix_t PI = `PI_FIX;
  localparam fix_t TWO_PI = 2 * `PI_FIX;

  typedef enum logic [1:0] {
    IDLE,     // wait for final pose
    ANGLE,    // next absolute angle, raise req
    WAIT_ACK,
    RELEASE   // req dropped, wait for ack low
  } chain_state_t;

  chain_state_t fsm;
  logic [LINK_W-1:0] link;
  fix_t joint [`NUM_LINKS]; // latched joint angles
  fix_t ang_sum;
  fix_t ang_wrapped;
  point_t pos; // end of the current link

  // trig.angle doubles as the running absolute angle
  assign ang_sum = trig.angle + joint[link];

  always_comb begin
    if (ang_sum > PI)
      ang_wrapped = ang_sum - TWO_PI;
    else if (ang_sum < -PI)
      ang_wrapped = ang_sum + TWO_PI;
    else
      ang_wrapped = ang_sum;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fsm <= IDLE;
      link <= '0;
      trig.req <= 1'b0;
      tip_valid <= 1'b0;
    end else begin
      tip_valid <= 1'b0;
      case (fsm)
        IDLE: begin
          if (steps_done) begin
            link <= '0;
            fsm <= ANGLE;
          end
        end
        ANGLE: begin
          trig.req <= 1'b1; // angle registered on the same edge
          fsm <= WAIT_ACK;
        end
        WAIT_ACK: begin
          if (trig.ack) begin
            trig.req <= 1'b0;
            fsm <= RELEASE;
          end
        end
        RELEASE: begin
          if (!trig.ack) begin
            if (link == LINK_W'(`NUM_LINKS - 1)) begin
              tip_valid <= 1'b1;
              fsm <= IDLE;
            end else begin
              link <= link + 1'b1;
              fsm <= ANGLE;
            end
          end
        end
        default: fsm <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (fsm)
      IDLE: begin
        if (steps_done) begin
          for (int k = 0; k < `NUM_LINKS; k++) begin
            joint[k] <= state[k + 2];
          end
          pos.x <= state[0]; // chain starts at the base
          pos.y <= state[1];
          trig.angle <= '0;
        end
      end
      ANGLE: trig.angle <= ang_wrapped;
      WAIT_ACK: begin
        if (trig.ack) begin
          pos.x <= pos.x + trig.cos_out; // unit link length
          pos.y <= pos.y + trig.sin_out;
        end
      end
      RELEASE: begin
        if (!trig.ack && link == LINK_W'(`NUM_LINKS - 1))
          tip <= pos;
      end
      default: ;
    endcase
  end

endmodule

// ==== logic/result_sender.sv ====
`timescale 1ns/1ps
`include "arm_macros.svh"

module result_sender import arm_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       tip_valid,
  input  point_t     tip,
  input  logic       tx_busy,
  output logic [7:0] tx_data,
  output logic       new_tx_data,
  output logic       busy_out
);

  localparam int CNT_W = $clog2(`OUT_BYTES);
  localparam int SH_W = 2 * `FIX_W;

  logic [SH_W-1:0] shreg; // x word on top, msb goes first
  logic [CNT_W-1:0] sent;
  logic load;

  assign load = tip_valid && !busy_out;

  // byte leaves in the same cycle tx_busy is seen low
  assign new_tx_data = busy_out && !tx_busy;
  assign tx_data = shreg[SH_W-1 -: 8];

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_out <= 1'b0;
      sent <= '0;
    end else if (load) begin
      busy_out <= 1'b1;
      sent <= '0;
    end else if (new_tx_data) begin
      sent <= sent + 1'b1;
      if (sent == CNT_W'(`OUT_BYTES - 1))
        busy_out <= 1'b0; // eighth byte out
    end
  end

  always_ff @(posedge clk) begin
    if (load)
      shreg <= tip; // packed as {x, y}
    else if (new_tx_data)
      shreg <= shreg << 8; // next byte up
  end

endmodule

// ==== logic/arm_solver_top.sv ====
`timescale 1ns/1ps

module arm_solver_top import arm_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] rx_data,
  input  logic       new_rx_data,
  input  logic       tx_busy,
  output logic [7:0] tx_data,
  output logic       new_tx_data
);

  logic start;
  logic [31:0] iter_count;
  state_vec_t state;
  logic steps_done;
  logic tip_valid;
  point_t tip;
  logic busy_out; // sender still draining, receiver holds off

  trig_if trig_bus ();

  cmd_receiver u_cmd_receiver (
    .clk         (clk),
    .rst         (rst),
    .rx_data     (rx_data),
    .new_rx_data (new_rx_data),
    .busy        (busy_out),
    .start       (start),
    .iter_count  (iter_count)
  );

  grad_stepper u_grad_stepper (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .iter_count (iter_count),
    .state      (state),
    .steps_done (steps_done)
  );

  // forward kinematics, once per command
  link_chain u_link_chain (
    .clk        (clk),
    .rst        (rst),
    .steps_done (steps_done),
    .state      (state),
    .trig       (trig_bus.client),
    .tip_valid  (tip_valid),
    .tip        (tip)
  );

  cordic_rotator u_cordic_rotator (
    .clk  (clk),
    .rst  (rst),
    .trig (trig_bus.server)
  );

  result_sender u_result_sender (
    .clk         (clk),
    .rst         (rst),
    .tip_valid   (tip_valid),
    .tip         (tip),
    .tx_busy     (tx_busy),
    .tx_data     (tx_data),
    .new_tx_data (new_tx_data),
    .busy_out    (busy_out)
  );

endmodule

// ==== testbench/arm_solver_properties.sv ====
`timescale 1ns/1ps

module arm_solver_properties (
  input logic clk,
  input logic rst,
  input logic req,
  input logic ack,
  input logic tx_busy,
  input logic new_tx_data
);

  // client holds req until ack arrives
  req_held: assert property (@(posedge clk) disable iff (rst) (req && !ack) |=> req)
    else $error("req dropped before ack was seen");

  ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
    else $error("ack raised without a pending req");

  // back-pressure from the transmitter
  no_tx_when_busy: assert property (@(posedge clk) disable iff (rst) tx_busy |-> !new_tx_data)
    else $error("byte sent while tx_busy was high");

  quiet_after_reset: assert property (@(posedge clk) rst |=> !new_tx_data)
    else $error("new_tx_data high right after reset");

endmodule

// handshake side only, transmit inputs tied low
bind cordic_rotator arm_solver_properties u_trig_props (
  .clk (clk), .rst (rst), .req (trig.req), .ack (trig.ack),
  .tx_busy (1'b0), .new_tx_data (1'b0)
);

bind result_sender arm_solver_properties u_tx_props (
  .clk (clk), .rst (rst), .req (1'b0), .ack (1'b0),
  .tx_busy (tx_busy), .new_tx_data (new_tx_data)
);

// ==== testbench/arm_solver_tb.sv ====
`timescale 1ns/1ps
`include "arm_macros.svh"

module arm_solver_tb import arm_pkg::*;;

  localparam int PERIOD = 8;
  localparam int RESET_CYCLES = 5;
  localparam int SETTLE = 16; // quiet cycles around each command
  localparam int NUM_TESTS = 5;
  localparam int OVERHEAD = 300; // arg bytes, three cordic calls, tx stalls
  localparam int unsigned COUNTS [NUM_TESTS] = '{0, 1, 5, 200, 2000};
  localparam int NUM_JUNK = 4;
  localparam logic [7:0] JUNK [NUM_JUNK] = '{8'h78, 8'h00, 8'h48, 8'hff}; // none is "h"

  // one command with its expected tip
  typedef struct packed {
    logic [31:0] count;
    fix_t exp_x;
    fix_t exp_y;
  } test_entry_t;

  logic clk = 1'b0;
  logic rst;
  logic [7:0] rx_data;
  logic new_rx_data;
  logic tx_busy;
  logic [7:0] tx_data;
  logic new_tx_data;

  test_entry_t tests [NUM_TESTS];
  logic [7:0] rx_bytes [$]; // bytes seen on the transmit side
  logic [31:0] lfsr = 32'hbb20_6552;
  int errors = 0;
  int checks = 0;

  arm_solver_top DUT (
    .clk         (clk),
    .rst         (rst),
    .rx_data     (rx_data),
    .new_rx_data (new_rx_data),
    .tx_busy     (tx_busy),
    .tx_data     (tx_data),
    .new_tx_data (new_tx_data)
  );

  always #(PERIOD / 2) clk = ~clk;

  // sample mid cycle, tx_data is stable while new_tx_data is high
  always @(negedge clk) begin
    if (!rst && new_tx_data)
      rx_bytes.push_back(tx_data);
  end

  // galois lfsr, taps 32 22 2 1
  function automatic logic take_bit();
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    return lfsr[0];
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
      v = (v << 1) | int'(take_bit());
    return v;
  endfunction

  // rotation mode cordic with quarter turn fold, integer q16.16
  function automatic void cordic_model(input int angle, output int cos_v, output int sin_v);
    int x;
    int y;
    int z;
    int xn;
    if (angle > `HALF_PI_FIX) begin
      x = 0;
      y = `CORDIC_GAIN_INV; // start at +90 deg
      z = angle - `HALF_PI_FIX;
    end else if (angle < -`HALF_PI_FIX) begin
      x = 0;
      y = -`CORDIC_GAIN_INV; // start at -90 deg
      z = angle + `HALF_PI_FIX;
    end else begin
      x = `CORDIC_GAIN_INV;
      y = 0;
      z = angle;
    end
    for (int i = 0; i < `CORDIC_ITERS; i++) begin
      if (z >= 0) begin
        xn = x - (y >>> i);
        y = y + (x >>> i);
        z = z - atan_table[i];
      end else begin
        xn = x + (y >>> i);
        y = y - (x >>> i);
        z = z + atan_table[i];
      end
      x = xn;
    end
    cos_v = x;
    sin_v = y;
  endfunction

  // state carries over, so commands are modelled in table order
  task automatic build_expected();
    int st [`NUM_STATE];
    int ang;
    int c;
    int s;
    int px;
    int py;
    foreach (st[i]) st[i] = 0; // reset pose
    for (int t = 0; t < NUM_TESTS; t++) begin
      for (int unsigned n = 0; n < COUNTS[t]; n++) begin
        for (int i = 0; i < `NUM_STATE; i++)
          st[i] = st[i] - ((bias_vec[i] + st[i]) >>> `STEP_SHIFT);
      end
      px = st[0]; // base
      py = st[1];
      ang = 0;
      for (int k = 0; k < `NUM_LINKS; k++) begin
        ang = ang + st[k + 2]; // absolute link angle
        if (ang > `PI_FIX)
          ang = ang - 2 * `PI_FIX;
        else if (ang < -`PI_FIX)
          ang = ang + 2 * `PI_FIX;
        cordic_model(ang, c, s);
        px = px + c; // unit links
        py = py + s;
      end
      tests[t].count = COUNTS[t];
      tests[t].exp_x = px;
      tests[t].exp_y = py;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("[FAIL] %s: expected %h, got %h", name, exp, act);
    end
  endtask

  // one byte with a random idle gap of 0..3 cycles in front
  task automatic send_byte(input logic [7:0] b);
    int gap;
    gap = take_bits(2);
    repeat (gap) @(posedge clk);
    @(posedge clk);
    rx_data <= b;
    new_rx_data <= 1'b1;
    @(posedge clk);
    new_rx_data <= 1'b0;
  endtask

  task automatic send_command(input logic [31:0] count);
    send_byte(`CMD_BYTE);
    for (int i = `NUM_ARGS - 1; i >= 0; i--)
      send_byte(count[8*i +: 8]); // msb first
  endtask

  // random back-pressure until a full result has arrived
  task automatic collect_result();
    while (rx_bytes.size() < `OUT_BYTES) begin
      @(posedge clk);
      tx_busy <= take_bit();
    end
    @(posedge clk);
    tx_busy <= 1'b0;
    repeat (SETTLE) @(posedge clk); // any extra byte would show up here
  endtask

  initial begin
    string name;
    logic [31:0] got_x;
    logic [31:0] got_y;
    rst = 1'b1;
    rx_data = '0;
    new_rx_data = 1'b0;
    tx_busy = 1'b0;
    build_expected();
    // all-zero pose should land near (3.0, 0)
    checks++;
    assert ((tests[0].exp_x - 196608 < 64) && (196608 - tests[0].exp_x < 64) &&
            (tests[0].exp_y < 64) && (tests[0].exp_y > -64)) else begin
      errors++;
      $display("reference model tip for the zero pose is not close to (3.0, 0)");
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    repeat (SETTLE) @(posedge clk);
    check_word("quiet_after_reset", 0, rx_bytes.size());
    // junk while idle, each trailed by a zero count that would answer if it were taken
    for (int j = 0; j < NUM_JUNK; j++) begin
      send_byte(JUNK[j]);
      repeat (`NUM_ARGS) send_byte(8'h00);
    end
    repeat (OVERHEAD) @(posedge clk); // longer than a count-0 result takes
    check_word("junk_ignored", 0, rx_bytes.size());
    for (int t = 0; t < NUM_TESTS; t++) begin
      name = $sformatf("count_%0d", tests[t].count);
      send_command(tests[t].count);
      collect_result();
      check_word({name, "_bytes"}, `OUT_BYTES, rx_bytes.size());
      if (rx_bytes.size() >= `OUT_BYTES) begin
        got_x = {rx_bytes[0], rx_bytes[1], rx_bytes[2], rx_bytes[3]};
        got_y = {rx_bytes[4], rx_bytes[5], rx_bytes[6], rx_bytes[7]};
        check_word({name, "_tip_x"}, tests[t].exp_x, got_x);
        check_word({name, "_tip_y"}, tests[t].exp_y, got_y);
      end
      rx_bytes.delete();
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  // run limit from the total step count plus a margin per command
  initial begin
    int limit;
    limit = RESET_CYCLES + 4 * SETTLE + 200 + OVERHEAD; // junk phase included
    for (int t = 0; t < NUM_TESTS; t++)
      limit = limit + int'(COUNTS[t]) + OVERHEAD;
    #(limit * PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", limit);
    $display("tests failed");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+logic
logic/arm_pkg.sv
logic/trig_if.sv
logic/cmd_receiver.sv
logic/grad_stepper.sv
logic/cordic_rotator.sv
logic/link_chain.sv
logic/result_sender.sv
logic/arm_solver_top.sv
testbench/arm_solver_properties.sv
testbench/arm_solver_tb.sv

// ==== Bender.yml ====
package:
  name: arm_solver

sources:
  - include_dirs:
      - logic
    files:
      - logic/arm_pkg.sv
      - logic/trig_if.sv
      - logic/cmd_receiver.sv
      - logic/grad_stepper.sv
      - logic/cordic_rotator.sv
      - logic/link_chain.sv
      - logic/result_sender.sv
      - logic/arm_solver_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/arm_solver_properties.sv
      - testbench/arm_solver_tb.sv
